// ==== rob_pkg.sv ====
// reorder buffer shared types
package rob_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int DISP_SIZE = 2;
  localparam int PC_W      = 32;
  localparam int RNID_W    = 6;
  // entry index plus wrap bit, up to 16 entries
  localparam int CMT_ID_W  = 5;
  localparam int WB_ADR_W  = 4;
  localparam int WB_DAT_W  = 32;

  typedef logic [DISP_SIZE-1:0] grp_id_t;
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;

  // ----------------------------------------
  // enums
  // ----------------------------------------
  typedef enum logic [3:0] {
    EXC_NONE           = 4'd0,
    EXC_INST_MISALIGN  = 4'd1,
    EXC_INST_ACC_FAULT = 4'd2,
    EXC_ILLEGAL_INST   = 4'd3,
    EXC_ECALL          = 4'd4,
    EXC_LOAD_FAULT     = 4'd5
  } except_t;

  // byte addresses on the register bus
  typedef enum logic [WB_ADR_W-1:0] {
    CSR_CTRL     = 4'h0,
    CSR_CMT_CNT  = 4'h4,
    CSR_DEAD_CNT = 4'h8,
    CSR_EXC_CNT  = 4'hc
  } csr_addr_e;

  // ----------------------------------------
  // structs
  // ----------------------------------------
  typedef struct packed {
    logic              valid;
    logic              wr_valid;
    logic [RNID_W-1:0] rnid;
    logic [RNID_W-1:0] old_rnid;
    logic              fe_except_valid;
    except_t           fe_except_type;
  } disp_inst_t;

  typedef struct packed {
    logic [PC_W-1:0]               pc;
    disp_inst_t [DISP_SIZE-1:0]    inst;
  } disp_grp_t;

  // grp_id is one-hot on the reported slot
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    logic    except_valid;
    except_t except_type;
  } done_rpt_t;

  typedef struct packed {
    logic                             valid;
    logic [PC_W-1:0]                  pc;
    grp_id_t                          grp_id;
    grp_id_t                          done_grp_id;
    grp_id_t                          dead;
    grp_id_t                          except_valid;
    except_t [DISP_SIZE-1:0]          except_type;
    grp_id_t                          wr_valid;
    logic [DISP_SIZE-1:0][RNID_W-1:0] rnid;
    logic [DISP_SIZE-1:0][RNID_W-1:0] old_rnid;
  } rob_entry_t;

  typedef struct packed {
    cmt_id_t         cmt_id;
    grp_id_t         grp_id;
    grp_id_t         dead_id;
    logic            except_valid;
    except_t         except_type;
    logic [PC_W-1:0] epc;
  } commit_t;

  typedef struct packed {
    logic                             commit;
    grp_id_t                          rnid_valid;
    logic [DISP_SIZE-1:0][RNID_W-1:0] rd_rnid;
    logic [DISP_SIZE-1:0][RNID_W-1:0] old_rnid;
    grp_id_t                          dead_id;
    logic                             except_valid;
  } rnid_upd_t;

endpackage

// ==== rob_entry_array.sv ====
// reorder buffer entry storage
`timescale 1ns/1ps

module rob_entry_array
  import rob_pkg::*;
#(
  parameter int ENTRY_COUNT = 8,
  parameter int DONE_PORTS  = 2
) (
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_disp_valid,
  input  disp_grp_t  i_disp,
  input  done_rpt_t  i_done_rpt [DONE_PORTS],
  input  logic       i_retire,
  input  logic       i_kill,
  output logic       o_disp_ready,
  output cmt_id_t    o_new_cmt_id,
  output rob_entry_t o_head,
  output cmt_id_t    o_head_id,
  output logic       o_head_all_done
);

  localparam int IDX_W = $clog2(ENTRY_COUNT);

  logic [IDX_W:0]         r_in_ptr;
  logic [IDX_W:0]         r_out_ptr;
  logic [ENTRY_COUNT-1:0] r_valid;
  rob_entry_t             r_entries [ENTRY_COUNT];

  rob_entry_t             w_entry_in;
  logic [IDX_W-1:0]       w_in_idx;
  logic [IDX_W-1:0]       w_out_idx;
  logic                   w_full;
  logic                   w_accept;

  assign w_in_idx  = r_in_ptr[IDX_W-1:0];
  assign w_out_idx = r_out_ptr[IDX_W-1:0];

  // same index with different wrap bits means every entry is taken
  assign w_full   = (r_in_ptr[IDX_W] != r_out_ptr[IDX_W]) && (w_in_idx == w_out_idx);
  assign w_accept = i_disp_valid & ~w_full;

  assign o_disp_ready = ~w_full;
  assign o_new_cmt_id = cmt_id_t'(r_in_ptr);
  assign o_head_id    = cmt_id_t'(r_out_ptr);

  // ----------------------------------------
  // in and out pointers
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (w_accept) begin
        r_in_ptr <= r_in_ptr + 1'b1;
      end
      if (i_retire) begin
        r_out_ptr <= r_out_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // new entry from the dispatch group
  // ----------------------------------------
  always_comb begin
    w_entry_in.valid = 1'b1;
    w_entry_in.pc    = i_disp.pc;
    w_entry_in.dead  = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_entry_in.grp_id[d]       = i_disp.inst[d].valid;
      // empty slots and frontend faults need no report
      w_entry_in.done_grp_id[d]  = ~i_disp.inst[d].valid | i_disp.inst[d].fe_except_valid;
      w_entry_in.except_valid[d] = i_disp.inst[d].valid & i_disp.inst[d].fe_except_valid;
      w_entry_in.except_type[d]  = w_entry_in.except_valid[d] ?
                                   i_disp.inst[d].fe_except_type : EXC_NONE;
      w_entry_in.wr_valid[d]     = i_disp.inst[d].valid & i_disp.inst[d].wr_valid;
      w_entry_in.rnid[d]         = i_disp.inst[d].rnid;
      w_entry_in.old_rnid[d]     = i_disp.inst[d].old_rnid;
    end
    // group arriving alongside a kill is born dead
    if (i_kill) begin
      w_entry_in.dead        = w_entry_in.grp_id;
      w_entry_in.done_grp_id = '1;
    end
  end

  // ----------------------------------------
  // per-entry state
  // ----------------------------------------
  for (genvar e = 0; e < ENTRY_COUNT; e++) begin : g_entry
    logic       w_load;
    logic       w_retire_here;
    rob_entry_t w_next;

    assign w_load        = w_accept & (w_in_idx == IDX_W'(e));
    assign w_retire_here = i_retire & (w_out_idx == IDX_W'(e));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid[e] <= 1'b0;
      end else if (w_load) begin
        r_valid[e] <= 1'b1;
      end else if (w_retire_here) begin
        r_valid[e] <= 1'b0;
      end
    end

    always_comb begin
      w_next = r_entries[e];
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (i_done_rpt[p].valid && r_valid[e] &&
            (i_done_rpt[p].cmt_id[IDX_W-1:0] == IDX_W'(e))) begin
          w_next.done_grp_id = w_next.done_grp_id | i_done_rpt[p].grp_id;
          for (int d = 0; d < DISP_SIZE; d++) begin
            if (i_done_rpt[p].grp_id[d] && i_done_rpt[p].except_valid) begin
              w_next.except_valid[d] = 1'b1;
              w_next.except_type[d]  = i_done_rpt[p].except_type;
            end
          end
        end
      end
      // younger entries drain as all dead
      if (i_kill && r_valid[e]) begin
        w_next.dead        = w_next.grp_id;
        w_next.done_grp_id = '1;
      end
      if (w_load) begin
        w_next = w_entry_in;
      end
    end

    always_ff @(posedge i_clk) begin
      r_entries[e] <= w_next;
    end
  end

  // head view, valid comes from the reset vector
  always_comb begin
    o_head       = r_entries[w_out_idx];
    o_head.valid = r_valid[w_out_idx];
  end

  assign o_head_all_done = &o_head.done_grp_id;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_accept_into_free : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    w_accept |-> !r_valid[w_in_idx]
  ) else $error("group accepted into an occupied entry");

  for (genvar p = 0; p < DONE_PORTS; p++) begin : g_done_chk
    a_done_hits_valid : assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      i_done_rpt[p].valid |-> r_valid[i_done_rpt[p].cmt_id[IDX_W-1:0]]
    ) else $error("done report for an empty entry on port %0d", p);
  end

endmodule

// ==== rob_commit_sel.sv ====
// reorder buffer commit selection
`timescale 1ns/1ps

module rob_commit_sel
  import rob_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  rob_entry_t i_head,
  input  cmt_id_t    i_head_id,
  input  logic       i_head_all_done,
  input  logic       i_commit_en,
  output logic       o_retire,
  output logic       o_kill,
  output logic       o_commit_valid,
  output commit_t    o_commit,
  output rnid_upd_t  o_rnid_upd
);

  localparam int SLOT_W = $clog2(DISP_SIZE);

  logic              w_retire;
  grp_id_t           w_exc_cand;
  grp_id_t           w_dead_above;
  logic              w_exc_any;
  logic [SLOT_W-1:0] w_exc_idx;
  except_t           w_exc_type;
  commit_t           w_commit;
  rnid_upd_t         w_rnid_upd;

  logic              r_commit_valid;
  commit_t           r_commit;
  rnid_upd_t         r_rnid_upd;

  assign w_retire = i_head.valid & i_head_all_done & i_commit_en;

  // stored dead bits mask out faults from killed slots
  assign w_exc_cand = i_head.except_valid & ~i_head.dead & i_head.grp_id;

  // ----------------------------------------
  // lowest excepting slot
  // ----------------------------------------
  always_comb begin
    w_exc_any    = 1'b0;
    w_exc_idx    = '0;
    w_exc_type   = EXC_NONE;
    w_dead_above = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_exc_any) begin
        w_dead_above[d] = 1'b1;
      end else if (w_exc_cand[d]) begin
        w_exc_any  = 1'b1;
        w_exc_idx  = SLOT_W'(d);
        w_exc_type = i_head.except_type[d];
      end
    end
  end

  // ----------------------------------------
  // commit and rename records
  // ----------------------------------------
  always_comb begin
    w_commit.cmt_id       = i_head_id;
    w_commit.grp_id       = i_head.grp_id;
    w_commit.dead_id      = (i_head.dead | w_dead_above) & i_head.grp_id;
    w_commit.except_valid = w_exc_any;
    w_commit.except_type  = w_exc_type;
    // four bytes per slot
    w_commit.epc          = i_head.pc + PC_W'({w_exc_idx, 2'b00});
  end

  always_comb begin
    w_rnid_upd.commit       = w_retire;
    w_rnid_upd.rnid_valid   = i_head.wr_valid;
    w_rnid_upd.rd_rnid      = i_head.rnid;
    w_rnid_upd.old_rnid     = i_head.old_rnid;
    w_rnid_upd.dead_id      = w_commit.dead_id;
    w_rnid_upd.except_valid = w_exc_any;
  end

  assign o_retire = w_retire;
  assign o_kill   = w_retire & w_exc_any;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_commit_valid <= 1'b0;
    end else begin
      r_commit_valid <= w_retire;
    end
  end

  always_ff @(posedge i_clk) begin
    r_commit   <= w_commit;
    r_rnid_upd <= w_rnid_upd;
  end

  assign o_commit_valid = r_commit_valid;
  assign o_commit       = r_commit;

  always_comb begin
    o_rnid_upd        = r_rnid_upd;
    o_rnid_upd.commit = r_commit_valid;
  end

  // an empty group must never reach commit
  a_commit_has_inst : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_commit_valid |-> (|o_commit.grp_id)
  ) else $error("commit of an entry with no instructions");

endmodule

// ==== rob_csr_wb.sv ====
// reorder buffer register block
`timescale 1ns/1ps

module rob_csr_wb
  import rob_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_wb_cyc,
  input  logic                i_wb_stb,
  input  logic                i_wb_we,
  input  logic [WB_ADR_W-1:0] i_wb_adr,
  input  logic [WB_DAT_W-1:0] i_wb_dat,
  input  logic                i_commit_valid,
  input  commit_t             i_commit,
  output logic [WB_DAT_W-1:0] o_wb_dat,
  output logic                o_wb_ack,
  output logic                o_commit_en
);

  localparam int INC_W = $clog2(DISP_SIZE + 1);

  csr_addr_e           w_adr;
  logic                w_req;
  logic                w_wr;
  logic [WB_DAT_W-1:0] w_rd_dat;
  logic [INC_W-1:0]    w_live_inc;
  logic [INC_W-1:0]    w_dead_inc;

  logic                r_ack;
  logic [WB_DAT_W-1:0] r_dat;
  logic                r_commit_en;
  logic [WB_DAT_W-1:0] r_cmt_cnt;
  logic [WB_DAT_W-1:0] r_dead_cnt;
  logic [WB_DAT_W-1:0] r_exc_cnt;

  assign w_adr = csr_addr_e'(i_wb_adr);
  // master holds until ack, so skip the cycle ack is high
  assign w_req = i_wb_cyc & i_wb_stb & ~r_ack;
  assign w_wr  = w_req & i_wb_we;

  assign w_live_inc = INC_W'($countones(i_commit.grp_id & ~i_commit.dead_id));
  assign w_dead_inc = INC_W'($countones(i_commit.grp_id & i_commit.dead_id));

  always_comb begin
    case (w_adr)
      CSR_CTRL:     w_rd_dat = {{(WB_DAT_W-1){1'b0}}, r_commit_en};
      CSR_CMT_CNT:  w_rd_dat = r_cmt_cnt;
      CSR_DEAD_CNT: w_rd_dat = r_dead_cnt;
      CSR_EXC_CNT:  w_rd_dat = r_exc_cnt;
      default:      w_rd_dat = '0;
    endcase
  end

  // ----------------------------------------
  // bus handshake and control
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ack       <= 1'b0;
      r_dat       <= '0;
      r_commit_en <= 1'b1;
    end else begin
      r_ack <= w_req;
      if (w_req) begin
        r_dat <= w_rd_dat;
      end
      if (w_wr && (w_adr == CSR_CTRL)) begin
        r_commit_en <= i_wb_dat[0];
      end
    end
  end

  // ----------------------------------------
  // retirement counters
  // ----------------------------------------
  // any write clears, taking priority over a commit in the same cycle
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cmt_cnt  <= '0;
      r_dead_cnt <= '0;
      r_exc_cnt  <= '0;
    end else begin
      if (w_wr && (w_adr == CSR_CMT_CNT)) begin
        r_cmt_cnt <= '0;
      end else if (i_commit_valid) begin
        r_cmt_cnt <= r_cmt_cnt + WB_DAT_W'(w_live_inc);
      end
      if (w_wr && (w_adr == CSR_DEAD_CNT)) begin
        r_dead_cnt <= '0;
      end else if (i_commit_valid) begin
        r_dead_cnt <= r_dead_cnt + WB_DAT_W'(w_dead_inc);
      end
      if (w_wr && (w_adr == CSR_EXC_CNT)) begin
        r_exc_cnt <= '0;
      end else if (i_commit_valid && i_commit.except_valid) begin
        r_exc_cnt <= r_exc_cnt + 1'b1;
      end
    end
  end

  assign o_wb_ack    = r_ack;
  assign o_wb_dat    = r_dat;
  assign o_commit_en = r_commit_en;

  a_ack_single : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_wb_ack |=> !o_wb_ack
  ) else $error("wishbone ack held for two cycles");

endmodule

// ==== rob_top.sv ====
// reorder buffer top level
`timescale 1ns/1ps

module rob_top
  import rob_pkg::*;
#(
  parameter int ENTRY_COUNT = 8,
  parameter int DONE_PORTS  = 2
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  // dispatch
  input  logic                i_disp_valid,
  input  disp_grp_t           i_disp,
  output logic                o_disp_ready,
  output cmt_id_t             o_new_cmt_id,
  // execution reports
  input  done_rpt_t           i_done_rpt [DONE_PORTS],
  // commit
  output logic                o_commit_valid,
  output commit_t             o_commit,
  output rnid_upd_t           o_rnid_upd,
  // register bus
  input  logic                i_wb_cyc,
  input  logic                i_wb_stb,
  input  logic                i_wb_we,
  input  logic [WB_ADR_W-1:0] i_wb_adr,
  input  logic [WB_DAT_W-1:0] i_wb_dat,
  output logic [WB_DAT_W-1:0] o_wb_dat,
  output logic                o_wb_ack
);

  rob_entry_t w_head;
  cmt_id_t    w_head_id;
  logic       w_head_all_done;
  logic       w_retire;
  logic       w_kill;
  logic       w_commit_en;

  rob_entry_array #(
    .ENTRY_COUNT (ENTRY_COUNT),
    .DONE_PORTS  (DONE_PORTS)
  ) u_entry_array (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (i_disp_valid),
    .i_disp          (i_disp),
    .i_done_rpt      (i_done_rpt),
    .i_retire        (w_retire),
    .i_kill          (w_kill),
    .o_disp_ready    (o_disp_ready),
    .o_new_cmt_id    (o_new_cmt_id),
    .o_head          (w_head),
    .o_head_id       (w_head_id),
    .o_head_all_done (w_head_all_done)
  );

  rob_commit_sel u_commit_sel (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_head          (w_head),
    .i_head_id       (w_head_id),
    .i_head_all_done (w_head_all_done),
    .i_commit_en     (w_commit_en),
    .o_retire        (w_retire),
    .o_kill          (w_kill),
    .o_commit_valid  (o_commit_valid),
    .o_commit        (o_commit),
    .o_rnid_upd      (o_rnid_upd)
  );

  rob_csr_wb u_csr_wb (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .i_commit_valid (o_commit_valid),
    .i_commit       (o_commit),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .o_commit_en    (w_commit_en)
  );

endmodule

// ==== tb_rob_top.sv ====
// reorder buffer testbench
`timescale 1ns/1ps

module tb_rob_top;
  import rob_pkg::*;

  localparam int ENTRY_COUNT = 8;
  localparam int DONE_PORTS  = 2;
  localparam int TIMEOUT     = 200;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_disp_valid;
  disp_grp_t           i_disp;
  logic                o_disp_ready;
  cmt_id_t             o_new_cmt_id;
  done_rpt_t           i_done_rpt [DONE_PORTS];
  logic                o_commit_valid;
  commit_t             o_commit;
  rnid_upd_t           o_rnid_upd;
  logic                i_wb_cyc;
  logic                i_wb_stb;
  logic                i_wb_we;
  logic [WB_ADR_W-1:0] i_wb_adr;
  logic [WB_DAT_W-1:0] i_wb_dat;
  logic [WB_DAT_W-1:0] o_wb_dat;
  logic                o_wb_ack;

  integer seed;
  // retirement totals kept from the expected commits
  int     live_cnt;
  int     dead_cnt;
  int     exc_cnt;
  // groups accepted so far
  int     disp_count;

  rob_top #(
    .ENTRY_COUNT (ENTRY_COUNT),
    .DONE_PORTS  (DONE_PORTS)
  ) i_rob_top (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp         (i_disp),
    .o_disp_ready   (o_disp_ready),
    .o_new_cmt_id   (o_new_cmt_id),
    .i_done_rpt     (i_done_rpt),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .o_rnid_upd     (o_rnid_upd),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack)
  );

  always #20 i_clk = ~i_clk;

  // ----------------------------------------
  // failure and compare tasks
  // ----------------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_commit(input commit_t got, input commit_t exp);
    // cause and epc only carry meaning with an exception
    if (got.cmt_id !== exp.cmt_id || got.grp_id !== exp.grp_id ||
        got.dead_id !== exp.dead_id || got.except_valid !== exp.except_valid ||
        (exp.except_valid && (got.except_type !== exp.except_type || got.epc !== exp.epc))) begin
      stop_run($sformatf("error at %0t: commit got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_rnid_upd(input rnid_upd_t got, input rnid_upd_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: rename update got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_cmt_id(input cmt_id_t got, input cmt_id_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: next commit id got %0d expected %0d", $time, got, exp));
    end
  endtask

  task automatic check_wb_data(input logic [WB_DAT_W-1:0] got,
                               input logic [WB_DAT_W-1:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: %s read %0d expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: %s is %b expected %b", $time, what, got, exp));
    end
  endtask

  // ----------------------------------------
  // expected values
  // ----------------------------------------
  function automatic commit_t expect_commit(input cmt_id_t id, input disp_grp_t g,
                                            input grp_id_t exc_mask, input except_t cause,
                                            input bit killed);
    commit_t c;
    int      slot;
    c.cmt_id       = id;
    c.dead_id      = '0;
    c.except_valid = 1'b0;
    c.except_type  = EXC_NONE;
    c.epc          = g.pc;
    slot           = -1;
    for (int d = 0; d < DISP_SIZE; d++) begin
      c.grp_id[d] = g.inst[d].valid;
    end
    if (killed) begin
      c.dead_id = c.grp_id;
    end else begin
      // lowest excepting slot wins, slots above it die
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (slot >= 0) begin
          c.dead_id[d] = c.grp_id[d];
        end else if (exc_mask[d] && c.grp_id[d]) begin
          slot = d;
        end
      end
    end
    if (slot >= 0) begin
      c.except_valid = 1'b1;
      c.except_type  = cause;
      c.epc          = g.pc + 32'(4 * slot);
    end
    return c;
  endfunction

  function automatic rnid_upd_t expect_rnid_upd(input disp_grp_t g, input commit_t c);
    rnid_upd_t u;
    u.commit       = 1'b1;
    u.dead_id      = c.dead_id;
    u.except_valid = c.except_valid;
    for (int d = 0; d < DISP_SIZE; d++) begin
      u.rnid_valid[d] = g.inst[d].valid & g.inst[d].wr_valid;
      u.rd_rnid[d]    = g.inst[d].rnid;
      u.old_rnid[d]   = g.inst[d].old_rnid;
    end
    return u;
  endfunction

  // ----------------------------------------
  // bus and port drivers
  // ----------------------------------------
  task automatic random_group(output disp_grp_t g, input bit fe0, input except_t fe_type);
    logic [31:0] r;
    r    = $random(seed);
    g.pc = {r[31:2], 2'b00};
    for (int d = 0; d < DISP_SIZE; d++) begin
      r                         = $random(seed);
      g.inst[d].valid           = 1'b1;
      g.inst[d].wr_valid        = r[12];
      g.inst[d].rnid            = r[5:0];
      g.inst[d].old_rnid        = r[11:6];
      g.inst[d].fe_except_valid = 1'b0;
      g.inst[d].fe_except_type  = EXC_NONE;
    end
    g.inst[0].fe_except_valid = fe0;
    g.inst[0].fe_except_type  = fe_type;
  endtask

  task automatic dispatch_group(input disp_grp_t g, output cmt_id_t id);
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_disp_ready) begin
      n++;
      if (n > TIMEOUT) stop_run("timeout waiting for dispatch ready");
      @(negedge i_clk);
    end
    // ids count over twice the entry count, top bit marks the wrap
    id = cmt_id_t'(disp_count % (2 * ENTRY_COUNT));
    check_cmt_id(o_new_cmt_id, id);
    @(posedge i_clk);
    i_disp_valid <= 1'b1;
    i_disp       <= g;
    @(posedge i_clk);
    i_disp_valid <= 1'b0;
    disp_count++;
  endtask

  // slot p always reports on port p
  task automatic report_done(input cmt_id_t id, input grp_id_t slots,
                             input grp_id_t exc_mask, input except_t cause);
    done_rpt_t r;
    @(posedge i_clk);
    for (int p = 0; p < DONE_PORTS; p++) begin
      r              = '0;
      r.valid        = slots[p];
      r.cmt_id       = id;
      r.grp_id[p]    = 1'b1;
      r.except_valid = exc_mask[p];
      r.except_type  = exc_mask[p] ? cause : EXC_NONE;
      i_done_rpt[p] <= r;
    end
    @(posedge i_clk);
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_rpt[p] <= '0;
    end
  endtask

  task automatic expect_retire(input cmt_id_t id, input disp_grp_t g, input grp_id_t exc_mask,
                               input except_t cause, input bit killed);
    commit_t   c;
    rnid_upd_t u;
    int        n;
    c = expect_commit(id, g, exc_mask, cause, killed);
    u = expect_rnid_upd(g, c);
    n = 0;
    @(negedge i_clk);
    while (!o_commit_valid) begin
      n++;
      if (n > TIMEOUT) stop_run("timeout waiting for a commit");
      @(negedge i_clk);
    end
    check_commit(o_commit, c);
    check_rnid_upd(o_rnid_upd, u);
    live_cnt += $countones(c.grp_id & ~c.dead_id);
    dead_cnt += $countones(c.grp_id & c.dead_id);
    if (c.except_valid) exc_cnt++;
  endtask

  task automatic wb_access(input bit we, input csr_addr_e adr, input logic [WB_DAT_W-1:0] wdat,
                           output logic [WB_DAT_W-1:0] rdat);
    int n;
    n = 0;
    @(posedge i_clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= we;
    i_wb_adr <= adr;
    i_wb_dat <= wdat;
    @(negedge i_clk);
    while (!o_wb_ack) begin
      n++;
      if (n > TIMEOUT) stop_run("timeout waiting for wishbone ack");
      @(negedge i_clk);
    end
    rdat = o_wb_dat;
    @(posedge i_clk);
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_in_order();
    disp_grp_t g [4];
    cmt_id_t   id [4];
    for (int i = 0; i < 4; i++) begin
      random_group(g[i], 1'b0, EXC_NONE);
      dispatch_group(g[i], id[i]);
    end
    for (int i = 3; i >= 0; i--) begin
      report_done(id[i], 2'b11, 2'b00, EXC_NONE);
    end
    for (int i = 0; i < 4; i++) begin
      expect_retire(id[i], g[i], 2'b00, EXC_NONE, 1'b0);
    end
  endtask

  task automatic test_fe_exception();
    disp_grp_t g;
    cmt_id_t   id;
    random_group(g, 1'b1, EXC_ILLEGAL_INST);
    dispatch_group(g, id);
    // slot 0 is done at dispatch
    report_done(id, 2'b10, 2'b00, EXC_NONE);
    expect_retire(id, g, 2'b01, EXC_ILLEGAL_INST, 1'b0);
  endtask

  task automatic test_kill();
    disp_grp_t g [3];
    cmt_id_t   id [3];
    for (int i = 0; i < 3; i++) begin
      random_group(g[i], 1'b0, EXC_NONE);
      dispatch_group(g[i], id[i]);
    end
    report_done(id[1], 2'b11, 2'b00, EXC_NONE);
    report_done(id[2], 2'b11, 2'b00, EXC_NONE);
    report_done(id[0], 2'b11, 2'b10, EXC_LOAD_FAULT);
    expect_retire(id[0], g[0], 2'b10, EXC_LOAD_FAULT, 1'b0);
    expect_retire(id[1], g[1], 2'b00, EXC_NONE, 1'b1);
    expect_retire(id[2], g[2], 2'b00, EXC_NONE, 1'b1);
  endtask

  task automatic test_full();
    disp_grp_t g [ENTRY_COUNT+1];
    cmt_id_t   id [ENTRY_COUNT+1];
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      random_group(g[i], 1'b0, EXC_NONE);
      dispatch_group(g[i], id[i]);
    end
    @(negedge i_clk);
    check_flag(o_disp_ready, 1'b0, "dispatch ready with buffer full");
    report_done(id[0], 2'b11, 2'b00, EXC_NONE);
    expect_retire(id[0], g[0], 2'b00, EXC_NONE, 1'b0);
    @(negedge i_clk);
    check_flag(o_disp_ready, 1'b1, "dispatch ready after a commit");
    random_group(g[ENTRY_COUNT], 1'b0, EXC_NONE);
    dispatch_group(g[ENTRY_COUNT], id[ENTRY_COUNT]);
    for (int i = 1; i <= ENTRY_COUNT; i++) begin
      report_done(id[i], 2'b11, 2'b00, EXC_NONE);
      expect_retire(id[i], g[i], 2'b00, EXC_NONE, 1'b0);
    end
  endtask

  task automatic test_csr();
    disp_grp_t           g;
    cmt_id_t             id;
    logic [WB_DAT_W-1:0] rd;
    wb_access(1'b1, CSR_CTRL, 32'h0, rd);
    random_group(g, 1'b0, EXC_NONE);
    dispatch_group(g, id);
    report_done(id, 2'b11, 2'b00, EXC_NONE);
    repeat (20) begin
      @(negedge i_clk);
      if (o_commit_valid) stop_run("commit appeared while commit enable was clear");
    end
    wb_access(1'b1, CSR_CTRL, 32'h1, rd);
    expect_retire(id, g, 2'b00, EXC_NONE, 1'b0);
    wb_access(1'b0, CSR_CTRL, 32'h0, rd);
    check_wb_data(rd, 32'h1, "control register");
    wb_access(1'b0, CSR_CMT_CNT, 32'h0, rd);
    check_wb_data(rd, 32'(live_cnt), "commit counter");
    wb_access(1'b0, CSR_DEAD_CNT, 32'h0, rd);
    check_wb_data(rd, 32'(dead_cnt), "dead counter");
    wb_access(1'b0, CSR_EXC_CNT, 32'h0, rd);
    check_wb_data(rd, 32'(exc_cnt), "exception counter");
    // any written value clears
    wb_access(1'b1, CSR_DEAD_CNT, 32'h5a5a, rd);
    wb_access(1'b0, CSR_DEAD_CNT, 32'h0, rd);
    check_wb_data(rd, 32'h0, "cleared dead counter");
  endtask

  initial begin
    seed         = 71;
    live_cnt     = 0;
    dead_cnt     = 0;
    exc_cnt      = 0;
    disp_count   = 0;
    i_clk        = 1'b0;
    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_disp       = '0;
    i_wb_cyc     = 1'b0;
    i_wb_stb     = 1'b0;
    i_wb_we      = 1'b0;
    i_wb_adr     = '0;
    i_wb_dat     = '0;
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_rpt[p] = '0;
    end
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check_flag(o_disp_ready, 1'b1, "dispatch ready after reset");
    check_flag(o_commit_valid, 1'b0, "commit valid after reset");
    check_flag(o_rnid_upd.commit, 1'b0, "rename update commit after reset");
    check_flag(o_wb_ack, 1'b0, "wishbone ack after reset");
    test_in_order();
    test_fe_exception();
    test_kill();
    test_full();
    test_csr();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
rob_pkg.sv
rob_entry_array.sv
rob_commit_sel.sv
rob_csr_wb.sv
rob_top.sv
tb_rob_top.sv

// ==== Makefile ====
TOP = tb_rob_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_rob
	./obj_dir/sim_rob

clean:
	rm -rf obj_dir
